// File: pwm_defines.svh
/* PWM chain build constants
   Channel count, datapath widths and the APB register map */
`ifndef PWM_DEFINES_SVH
`define PWM_DEFINES_SVH

// Channel count and datapath widths
`define PWM_N_CHANNELS    4
`define PWM_COUNTER_WIDTH 16
`define PWM_DEAD_WIDTH    16
`define PWM_ADDR_WIDTH    8
`define PWM_DATA_WIDTH    32

// Timer registers where mode bit 0 selects up-down counting
`define PWM_REG_MODE      8'h00
`define PWM_REG_PRESCALE  8'h04
`define PWM_REG_START     8'h08
`define PWM_REG_STOP      8'h0C

// Channel c keeps its on-threshold at base+8c and its off-threshold 4 above
`define PWM_REG_THR_BASE  8'h10

// Two output enables per channel with side A in the even bit
`define PWM_REG_OUT_EN    8'h30
`define PWM_REG_DT_EN     8'h34

// Channel c dead time sits at base+4c
`define PWM_REG_DEAD_BASE 8'h40

`endif

// File: pwm_pkg.sv
/* Shared types of the PWM chain
   Width typedefs, counter mode and the APB and configuration records */
`include "pwm_defines.svh"

package pwm_pkg;

    typedef logic [`PWM_COUNTER_WIDTH-1:0] count_t;
    typedef logic [`PWM_DEAD_WIDTH-1:0]    dead_t;
    typedef logic [`PWM_ADDR_WIDTH-1:0]    apb_addr_t;
    typedef logic [`PWM_DATA_WIDTH-1:0]    apb_data_t;

    typedef enum logic {
        COUNT_UP      = 1'b0,
        COUNT_UP_DOWN = 1'b1
    } count_mode_t;

    typedef struct packed {
        apb_addr_t paddr;
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // Period setup of the shared counter
    typedef struct packed {
        count_mode_t mode;
        count_t      prescale;
        count_t      start;
        count_t      stop;
    } timer_cfg_t;

    // Per-channel compare window, pin enables and dead time
    typedef struct packed {
        count_t     on_thr;
        count_t     off_thr;
        logic [1:0] out_en;
        logic       dt_en;
        dead_t      dead;
    } channel_cfg_t;

endpackage

// File: pwm_control_unit.sv
/* PWM register file behind a zero-wait-state APB slave
   Holds the timer setup and the per-channel configuration */
`include "pwm_defines.svh"

module pwm_control_unit import pwm_pkg::*; (
    input  logic                               clock,
    input  logic                               reset,
    input  apb_req_t                           apb_req,
    output apb_rsp_t                           apb_rsp,
    output timer_cfg_t                         timer_cfg,
    output channel_cfg_t [`PWM_N_CHANNELS-1:0] channel_cfg
);

    localparam int N_CH = `PWM_N_CHANNELS;
    localparam int CH_W = $clog2(N_CH);

    timer_cfg_t              timer_q;
    channel_cfg_t [N_CH-1:0] chan_q;

    apb_addr_t       addr;
    apb_addr_t       thr_offset;
    apb_addr_t       dead_offset;
    logic [CH_W-1:0] thr_chan;
    logic [CH_W-1:0] dead_chan;
    logic            thr_hit;
    logic            dead_hit;
    logic            reg_hit;
    logic            access;
    logic            write_en;
    apb_data_t       rd_data;

    assign addr     = apb_req.paddr;
    assign access   = apb_req.psel && apb_req.penable;
    assign write_en = access && apb_req.pwrite && reg_hit;

    // The threshold and dead-time banks are decoded by their offset from the bank base
    assign thr_offset  = addr - `PWM_REG_THR_BASE;
    assign dead_offset = addr - `PWM_REG_DEAD_BASE;
    assign thr_chan    = thr_offset[3 +: CH_W];
    assign dead_chan   = dead_offset[2 +: CH_W];
    assign thr_hit     = (thr_offset < 8 * N_CH) && (addr[1:0] == 2'b00);
    assign dead_hit    = (dead_offset < 4 * N_CH) && (addr[1:0] == 2'b00);

    always_comb begin
        rd_data = '0;
        reg_hit = 1'b1;
        if (thr_hit) begin
            if (thr_offset[2]) begin
                rd_data = apb_data_t'(chan_q[thr_chan].off_thr);
            end else begin
                rd_data = apb_data_t'(chan_q[thr_chan].on_thr);
            end
        end else if (dead_hit) begin
            rd_data = apb_data_t'(chan_q[dead_chan].dead);
        end else begin
            case (addr)
                `PWM_REG_MODE:     rd_data = apb_data_t'(timer_q.mode);
                `PWM_REG_PRESCALE: rd_data = apb_data_t'(timer_q.prescale);
                `PWM_REG_START:    rd_data = apb_data_t'(timer_q.start);
                `PWM_REG_STOP:     rd_data = apb_data_t'(timer_q.stop);
                `PWM_REG_OUT_EN: begin
                    for (int c = 0; c < N_CH; c++) begin
                        rd_data[2*c +: 2] = chan_q[c].out_en;
                    end
                end
                `PWM_REG_DT_EN: begin
                    for (int c = 0; c < N_CH; c++) begin
                        rd_data[c] = chan_q[c].dt_en;
                    end
                end
                default: reg_hit = 1'b0;
            endcase
        end
    end

    // No wait states, so every access phase completes at once
    assign apb_rsp.prdata  = rd_data;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && !reg_hit;

    always_ff @(posedge clock) begin
        if (!reset) begin
            timer_q <= '{mode: COUNT_UP, prescale: '0, start: '0, stop: '1};
            chan_q  <= '0;
        end else if (write_en) begin
            if (thr_hit) begin
                if (thr_offset[2]) begin
                    chan_q[thr_chan].off_thr <= apb_req.pwdata[`PWM_COUNTER_WIDTH-1:0];
                end else begin
                    chan_q[thr_chan].on_thr <= apb_req.pwdata[`PWM_COUNTER_WIDTH-1:0];
                end
            end else if (dead_hit) begin
                chan_q[dead_chan].dead <= apb_req.pwdata[`PWM_DEAD_WIDTH-1:0];
            end else begin
                case (addr)
                    `PWM_REG_MODE:     timer_q.mode <= count_mode_t'(apb_req.pwdata[0]);
                    `PWM_REG_PRESCALE: timer_q.prescale <= apb_req.pwdata[`PWM_COUNTER_WIDTH-1:0];
                    `PWM_REG_START:    timer_q.start <= apb_req.pwdata[`PWM_COUNTER_WIDTH-1:0];
                    `PWM_REG_STOP:     timer_q.stop <= apb_req.pwdata[`PWM_COUNTER_WIDTH-1:0];
                    `PWM_REG_OUT_EN: begin
                        for (int c = 0; c < N_CH; c++) begin
                            chan_q[c].out_en <= apb_req.pwdata[2*c +: 2];
                        end
                    end
                    `PWM_REG_DT_EN: begin
                        for (int c = 0; c < N_CH; c++) begin
                            chan_q[c].dt_en <= apb_req.pwdata[c];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    assign timer_cfg   = timer_q;
    assign channel_cfg = chan_q;

endmodule

// File: pwm_counter.sv
/* Shared PWM time base
   Prescaled up or up-down counter that flags each period boundary */
module pwm_counter import pwm_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       running,
    input  timer_cfg_t timer_cfg,
    output count_t     count,
    output logic       reload
);

    count_t prescale_cnt;
    count_t count_q;
    logic   count_up;
    logic   reload_q;
    logic   tick;

    // One count step every prescale+1 clock cycles
    assign tick = (prescale_cnt >= timer_cfg.prescale);

    always_ff @(posedge clock) begin
        if (!reset) begin
            prescale_cnt <= '0;
        end else if (!running || tick) begin
            prescale_cnt <= '0;
        end else begin
            prescale_cnt <= prescale_cnt + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            count_q  <= '0;
            count_up <= 1'b1;
            reload_q <= 1'b0;
        end else if (!running) begin
            // Park at the start value so the first period after a start is whole
            count_q  <= timer_cfg.start;
            count_up <= 1'b1;
            reload_q <= 1'b0;
        end else begin
            reload_q <= 1'b0;
            if (tick) begin
                if (timer_cfg.mode == COUNT_UP) begin
                    count_up <= 1'b1;
                    if (count_q >= timer_cfg.stop) begin
                        count_q  <= timer_cfg.start;
                        reload_q <= 1'b1;
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end else if (count_up) begin
                    if (count_q < timer_cfg.stop) begin
                        count_q <= count_q + 1'b1;
                    end else if (count_q > timer_cfg.start) begin
                        // Turn around at the top of the triangle
                        count_q  <= count_q - 1'b1;
                        count_up <= 1'b0;
                    end else begin
                        count_q  <= timer_cfg.start;
                        reload_q <= 1'b1;
                    end
                end else begin
                    // The down slope ends at start+1 and the next step closes the period
                    if (count_q <= timer_cfg.start + 1'b1) begin
                        count_q  <= timer_cfg.start;
                        count_up <= 1'b1;
                        reload_q <= 1'b1;
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end
            end
        end
    end

    assign count  = count_q;
    assign reload = reload_q;

endmodule

// File: pwm_compare_unit.sv
/* Compare stage for all PWM channels
   Shadowed thresholds, window compare and gated complementary outputs */
`include "pwm_defines.svh"

module pwm_compare_unit import pwm_pkg::*; (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               running,
    input  count_t                             count,
    input  logic                               reload,
    input  channel_cfg_t [`PWM_N_CHANNELS-1:0] channel_cfg,
    output logic [`PWM_N_CHANNELS-1:0]         raw_a,
    output logic [`PWM_N_CHANNELS-1:0]         raw_b
);

    localparam int N_CH = `PWM_N_CHANNELS;

    count_t          on_shadow  [N_CH];
    count_t          off_shadow [N_CH];
    count_t          on_active  [N_CH];
    count_t          off_active [N_CH];
    logic            take_new;
    logic [N_CH-1:0] in_window;

    // Thresholds track the registers while stopped and latch at each period boundary
    assign take_new = reload || !running;

    always_ff @(posedge clock) begin
        if (take_new) begin
            for (int c = 0; c < N_CH; c++) begin
                on_shadow[c]  <= channel_cfg[c].on_thr;
                off_shadow[c] <= channel_cfg[c].off_thr;
            end
        end
    end

    // The boundary cycle itself already belongs to the new window
    always_comb begin
        for (int c = 0; c < N_CH; c++) begin
            on_active[c]  = take_new ? channel_cfg[c].on_thr : on_shadow[c];
            off_active[c] = take_new ? channel_cfg[c].off_thr : off_shadow[c];
            in_window[c]  = (count >= on_active[c]) && (count < off_active[c]);
        end
    end

    // Side B is the complement of side A before the enables are applied
    always_ff @(posedge clock) begin
        if (!reset) begin
            raw_a <= '0;
            raw_b <= '0;
        end else begin
            for (int c = 0; c < N_CH; c++) begin
                raw_a[c] <= in_window[c] && channel_cfg[c].out_en[0] && running;
                raw_b[c] <= !in_window[c] && channel_cfg[c].out_en[1] && running;
            end
        end
    end

endmodule

// File: pwm_dead_time.sv
/* Dead-time insertion for one complementary output pair
   Delays each rising edge until the opposite side has been low long enough */
module pwm_dead_time import pwm_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  enable,
    input  dead_t dead,
    input  logic  raw_a,
    input  logic  raw_b,
    output logic  out_a,
    output logic  out_b
);

    // Index 0 is side A and index 1 is side B
    logic [1:0] raw;
    logic [1:0] alone;
    logic [1:0] out_q;
    dead_t      guard_cnt [2];

    assign raw = {raw_b, raw_a};

    // A side may only drive while it is the sole one requested
    assign alone[0] = raw[0] && !raw[1];
    assign alone[1] = raw[1] && !raw[0];

    // Each guard counter restarts whenever its side stops being the only request
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int s = 0; s < 2; s++) begin
                guard_cnt[s] <= '0;
            end
        end else begin
            for (int s = 0; s < 2; s++) begin
                if (!alone[s]) begin
                    guard_cnt[s] <= '0;
                end else if (guard_cnt[s] < dead) begin
                    guard_cnt[s] <= guard_cnt[s] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_q <= '0;
        end else begin
            for (int s = 0; s < 2; s++) begin
                if (enable) begin
                    out_q[s] <= alone[s] && (guard_cnt[s] >= dead);
                end else begin
                    out_q[s] <= raw[s];
                end
            end
        end
    end

    assign out_a = out_q[0];
    assign out_b = out_q[1];

endmodule

// File: pwm_chain.sv
/* Four-channel PWM timer chain
   APB configured counter, compare stage and dead-time outputs */
`include "pwm_defines.svh"

module pwm_chain import pwm_pkg::*; (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       run,
    input  apb_req_t                   apb_req,
    output apb_rsp_t                   apb_rsp,
    output logic                       counter_status,
    output logic [`PWM_N_CHANNELS-1:0] out_a,
    output logic [`PWM_N_CHANNELS-1:0] out_b
);

    timer_cfg_t                         timer_cfg;
    channel_cfg_t [`PWM_N_CHANNELS-1:0] channel_cfg;
    count_t                             count;
    logic                               reload;
    logic                               running;
    logic [`PWM_N_CHANNELS-1:0]         raw_a;
    logic [`PWM_N_CHANNELS-1:0]         raw_b;

    // Registered run state shared by every block of the chain
    always_ff @(posedge clock) begin
        if (!reset) begin
            running <= 1'b0;
        end else begin
            running <= run;
        end
    end

    assign counter_status = running;

    pwm_control_unit control_unit (
        .clock       (clock),
        .reset       (reset),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .timer_cfg   (timer_cfg),
        .channel_cfg (channel_cfg)
    );

    pwm_counter counter (
        .clock     (clock),
        .reset     (reset),
        .running   (running),
        .timer_cfg (timer_cfg),
        .count     (count),
        .reload    (reload)
    );

    pwm_compare_unit compare_unit (
        .clock       (clock),
        .reset       (reset),
        .running     (running),
        .count       (count),
        .reload      (reload),
        .channel_cfg (channel_cfg),
        .raw_a       (raw_a),
        .raw_b       (raw_b)
    );

    for (genvar c = 0; c < `PWM_N_CHANNELS; c++) begin : gen_dead_time
        pwm_dead_time dead_time (
            .clock  (clock),
            .reset  (reset),
            .enable (channel_cfg[c].dt_en),
            .dead   (channel_cfg[c].dead),
            .raw_a  (raw_a[c]),
            .raw_b  (raw_b[c]),
            .out_a  (out_a[c]),
            .out_b  (out_b[c])
        );
    end

endmodule

// File: tb_clock_gen.sv
/* Testbench clock and active-low reset source */
module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Reset is released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
    end

endmodule

// File: pwm_chain_assertions.sv
/* Concurrent checks on the PWM chain ports
   Dead-time exclusion, APB error timing and the run status after reset */
`include "pwm_defines.svh"

module pwm_chain_assertions import pwm_pkg::*; (
    input logic                               clock,
    input logic                               reset,
    input apb_req_t                           apb_req,
    input apb_rsp_t                           apb_rsp,
    input logic                               counter_status,
    input logic [`PWM_N_CHANNELS-1:0]         out_a,
    input logic [`PWM_N_CHANNELS-1:0]         out_b,
    input channel_cfg_t [`PWM_N_CHANNELS-1:0] channel_cfg
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`PWM_N_CHANNELS-1:0] dt_en;

    always_comb begin
        for (int c = 0; c < `PWM_N_CHANNELS; c++) begin
            dt_en[c] = channel_cfg[c].dt_en;
        end
    end

    // A channel with dead time never drives both sides at once
    no_overlap: assert property (@(posedge clock) disable iff (!reset)
        ((out_a & out_b & dt_en) == '0))
        else $error("Both outputs of a dead-time channel are high");

    slverr_in_access: assert property (@(posedge clock) disable iff (!reset)
        apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
        else $error("pslverr is high outside an access phase");

    status_after_reset: assert property (@(posedge clock)
        !reset |=> !counter_status)
        else $error("counter_status is high right after reset");

endmodule

bind pwm_chain pwm_chain_assertions assertions0 (
    .clock          (clock),
    .reset          (reset),
    .apb_req        (apb_req),
    .apb_rsp        (apb_rsp),
    .counter_status (counter_status),
    .out_a          (out_a),
    .out_b          (out_b),
    .channel_cfg    (channel_cfg)
);

// File: pwm_chain_tb.sv
/* Directed testbench for the four-channel PWM chain
   Register access, duty cycle, dead time, enables, run control and shadow reload */
`include "pwm_defines.svh"

module pwm_chain_tb import pwm_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLOCK_PERIOD = 100;
    localparam int PERIOD_TOP   = 19;
    // Reset, registers, two duty tests, dead time and controls, then a margin
    localparam int WATCHDOG_CYCLES = 20 + 300 + 2 * 400 + 250 + 600 + 1000;

    logic                       clock;
    logic                       reset;
    logic                       run;
    apb_req_t                   apb_req;
    apb_rsp_t                   apb_rsp;
    logic                       counter_status;
    logic [`PWM_N_CHANNELS-1:0] out_a;
    logic [`PWM_N_CHANNELS-1:0] out_b;
    logic [31:0]                lfsr_state = 32'hdd98_c722;
    bit                         outcome_shown;

    tb_clock_gen #(
        .PERIOD       (CLOCK_PERIOD),
        .RESET_CYCLES (10)
    ) clock_gen (
        .clock (clock),
        .reset (reset)
    );

    pwm_chain dut0 (
        .clock          (clock),
        .reset          (reset),
        .run            (run),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .counter_status (counter_status),
        .out_a          (out_a),
        .out_b          (out_b)
    );

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < n; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic void show_failure();
        $display("*** TEST FAILED ***");
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        show_failure();
        outcome_shown = 1'b1;
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch on %s: got 0x%0h, expected 0x%0h",
                                        name, actual, expected));
        end
    endtask

    // Setup phase on one falling edge, access phase on the next
    task automatic apb_transfer(input apb_addr_t addr, input logic write, input apb_data_t wdata,
                                output apb_data_t rdata, output logic slverr);
        @(negedge clock);
        apb_req.paddr   = addr;
        apb_req.pwrite  = write;
        apb_req.pwdata  = wdata;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clock);
        apb_req.penable = 1'b1;
        @(negedge clock);
        check_equal("pready", apb_rsp.pready, 1);
        rdata           = apb_rsp.prdata;
        slverr          = apb_rsp.pslverr;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic slverr);
        apb_data_t unused;
        apb_transfer(addr, 1'b1, data, unused, slverr);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic slverr);
        apb_transfer(addr, 1'b0, '0, data, slverr);
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
        logic slverr;
        apb_write(addr, data, slverr);
        check_equal($sformatf("pslverr on write to 0x%02h", addr), slverr, 0);
    endtask

    function automatic apb_data_t register_mask(input apb_addr_t addr);
        case (addr)
            `PWM_REG_MODE:   return 32'h1;
            `PWM_REG_OUT_EN: return 32'hff;
            `PWM_REG_DT_EN:  return 32'hf;
            default:         return 32'hffff;
        endcase
    endfunction

    task automatic configure(input logic mode, input int prescale, input int on_thr,
                             input int off_thr, input apb_data_t out_en, input apb_data_t dt_en);
        write_reg(`PWM_REG_MODE, mode);
        write_reg(`PWM_REG_PRESCALE, prescale);
        write_reg(`PWM_REG_START, 0);
        write_reg(`PWM_REG_STOP, PERIOD_TOP);
        write_reg(`PWM_REG_THR_BASE, on_thr);
        write_reg(`PWM_REG_THR_BASE + 8'h4, off_thr);
        write_reg(`PWM_REG_OUT_EN, out_en);
        write_reg(`PWM_REG_DT_EN, dt_en);
    endtask

    // Returns at the first sample where out_a[0] is high after being low
    task automatic wait_rise_a();
        logic prev;
        prev = 1'b1;
        @(negedge clock);
        while (prev || !out_a[0]) begin
            prev = out_a[0];
            @(negedge clock);
        end
    endtask

    task automatic measure_pulse(output int width);
        wait_rise_a();
        width = 0;
        while (out_a[0]) begin
            width++;
            @(negedge clock);
        end
    endtask

    task automatic measure_period(input int edges, output int period, output int high);
        int   seen;
        logic prev;
        wait_rise_a();
        seen   = 0;
        period = 0;
        high   = 0;
        prev   = 1'b0;
        while (seen < edges) begin
            check_equal("out_b[0]", out_b[0], !out_a[0]);
            period++;
            if (out_a[0]) begin
                high++;
            end
            prev = out_a[0];
            @(negedge clock);
            if (!prev && out_a[0]) begin
                seen++;
            end
        end
    endtask

    task automatic test_registers();
        apb_addr_t addrs[$];
        apb_data_t expected[$];
        apb_data_t data;
        apb_data_t value;
        logic      slverr;
        apb_addr_t unmapped[3] = '{8'h12, 8'h3c, 8'h50};
        apb_read(`PWM_REG_STOP, data, slverr);
        check_equal("stop value after reset", data, 32'hffff);
        for (int a = 0; a < 'h50; a += 4) begin
            if (a != 'h38 && a != 'h3c) begin
                addrs.push_back(apb_addr_t'(a));
            end
        end
        foreach (addrs[i]) begin
            value = random_bits(32);
            expected.push_back(value & register_mask(addrs[i]));
            write_reg(addrs[i], value);
        end
        // Unmapped accesses go between the writes and the readback so any stray write shows
        foreach (unmapped[i]) begin
            apb_write(unmapped[i], random_bits(32), slverr);
            check_equal($sformatf("pslverr on write to 0x%02h", unmapped[i]), slverr, 1);
            apb_read(unmapped[i], data, slverr);
            check_equal($sformatf("pslverr on read of 0x%02h", unmapped[i]), slverr, 1);
            check_equal($sformatf("prdata at 0x%02h", unmapped[i]), data, 0);
        end
        foreach (addrs[i]) begin
            apb_read(addrs[i], data, slverr);
            check_equal($sformatf("pslverr on read of 0x%02h", addrs[i]), slverr, 0);
            check_equal($sformatf("prdata at 0x%02h", addrs[i]), data, expected[i]);
        end
    endtask

    task automatic test_duty(input logic mode);
        int prescale;
        int on_thr;
        int off_thr;
        int edges;
        int period;
        int high;
        prescale = random_bits(2);
        on_thr   = mode ? 1 + random_bits(8) % (PERIOD_TOP - 1) : random_bits(8) % PERIOD_TOP;
        off_thr  = on_thr + 1 + random_bits(8) % (PERIOD_TOP - on_thr);
        configure(mode, prescale, on_thr, off_thr, 32'h3, 32'h0);
        run = 1'b1;
        // Up-down mode makes two pulses in each period
        edges = mode ? 2 : 1;
        measure_period(edges, period, high);
        if (mode) begin
            check_equal("out_a[0] period", period, 2 * PERIOD_TOP * (prescale + 1));
        end else begin
            check_equal("out_a[0] period", period, (PERIOD_TOP + 1) * (prescale + 1));
        end
        check_equal("out_a[0] high count", high, edges * (off_thr - on_thr) * (prescale + 1));
        run = 1'b0;
        repeat (4) @(negedge clock);
    endtask

    task automatic test_dead_time();
        int   dead;
        int   low_run;
        int   rises;
        logic prev_a;
        logic prev_b;
        dead = 2 + random_bits(2);
        configure(1'b0, 0, 4, 14, 32'h3, 32'h1);
        write_reg(`PWM_REG_DEAD_BASE, dead);
        run = 1'b1;
        wait_rise_a();
        low_run = -1;
        rises   = 0;
        prev_a  = 1'b1;
        prev_b  = out_b[0];
        repeat (2 * (PERIOD_TOP + 1)) begin
            @(negedge clock);
            check_equal("out_a[0] & out_b[0]", out_a[0] & out_b[0], 0);
            if (((!prev_a && out_a[0]) || (!prev_b && out_b[0])) && low_run >= 0) begin
                rises++;
                if (low_run < dead) begin
                    stop_with_failure($sformatf("Dead-time gap of %0d cycles is below %0d",
                                                low_run, dead));
                end
            end
            // Length of the current gap with both sides low
            if (out_a[0] || out_b[0]) begin
                low_run = -1;
            end else if (prev_a || prev_b) begin
                low_run = 1;
            end else if (low_run >= 0) begin
                low_run++;
            end
            prev_a = out_a[0];
            prev_b = out_b[0];
        end
        if (rises < 3) begin
            stop_with_failure("Dead-time outputs did not toggle over two periods");
        end
        run = 1'b0;
        repeat (4) @(negedge clock);
        write_reg(`PWM_REG_DT_EN, 0);
    endtask

    task automatic test_controls();
        int width_before;
        int width_after;
        configure(1'b0, 0, 2, 8, 32'h2, 32'h0);
        run = 1'b1;
        repeat (3) @(negedge clock);
        check_equal("counter_status", counter_status, 1);
        repeat (2 * (PERIOD_TOP + 1)) begin
            @(negedge clock);
            check_equal("out_a[0] with its enable clear", out_a[0], 0);
        end
        write_reg(`PWM_REG_OUT_EN, 32'h1);
        repeat (3) @(negedge clock);
        repeat (2 * (PERIOD_TOP + 1)) begin
            @(negedge clock);
            check_equal("out_b[0] with its enable clear", out_b[0], 0);
        end
        write_reg(`PWM_REG_OUT_EN, 32'h3);
        // The off threshold moves from 8 to 14 while a pulse is in progress
        fork
            begin
                measure_pulse(width_before);
                measure_pulse(width_after);
            end
            begin
                wait_rise_a();
                write_reg(`PWM_REG_THR_BASE + 8'h4, 14);
            end
        join
        check_equal("high count in the period of the write", width_before, 8 - 2);
        check_equal("high count in the next period", width_after, 14 - 2);
        run = 1'b0;
        repeat (4) @(negedge clock);
        check_equal("counter_status", counter_status, 0);
        check_equal("out_a", out_a, 0);
        check_equal("out_b", out_b, 0);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        stop_with_failure("Watchdog expired before the tests finished");
    end

    initial begin
        run     = 1'b0;
        apb_req = '0;
        @(posedge reset);
        @(negedge clock);
        check_equal("counter_status after reset", counter_status, 0);
        check_equal("out_a after reset", out_a, 0);
        check_equal("out_b after reset", out_b, 0);
        test_registers();
        test_duty(1'b0);
        test_duty(1'b1);
        test_dead_time();
        test_controls();
        outcome_shown = 1'b1;
        $display("*** TEST PASSED ***");
        $finish;
    end

    final begin
        if (!outcome_shown) begin
            show_failure();
        end
    end

endmodule

// File: vlog.f
+incdir+.
pwm_pkg.sv
pwm_control_unit.sv
pwm_counter.sv
pwm_compare_unit.sv
pwm_dead_time.sv
pwm_chain.sv
tb_clock_gen.sv
pwm_chain_assertions.sv
pwm_chain_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the PWM chain simulation with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module pwm_chain_tb -f vlog.f -o pwm_chain_sim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/pwm_chain_sim > sim.log 2>&1
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation failed"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
